// File: account_arbiter.sv
module account_arbiter (
  input  logic                   clk,
  input  logic                   rst_n,
  input  pretrade_pkg::mem_req_t order_req,
  input  pretrade_pkg::mem_req_t limit_req,
  output logic                   order_gnt,
  output logic                   limit_gnt,
  output logic                   order_rvalid,
  output logic                   limit_rvalid,
  output pretrade_pkg::mem_req_t mem_req
);

  logic prio_lim_q;  // 1: limit engine wins a tie
  logic order_is_rd; // read, not write
  logic limit_is_rd;

  assign order_is_rd = !order_req.wr_lim && !order_req.wr_acc;
  assign limit_is_rd = !limit_req.wr_lim && !limit_req.wr_acc;

  // one grant per cycle, tie broken by the rr pointer
  assign order_gnt = order_req.en && (!limit_req.en || !prio_lim_q);
  assign limit_gnt = limit_req.en && (!order_req.en || prio_lim_q);

  // granted request goes straight to the store
  always_comb begin
    mem_req = '0;
    if (order_gnt) begin
      mem_req = order_req;
    end else if (limit_gnt) begin
      mem_req = limit_req;
    end
  end

  // priority moves away from whoever was just served
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prio_lim_q <= 1'b0;
    end else if (order_gnt) begin
      prio_lim_q <= 1'b1;
    end else if (limit_gnt) begin
      prio_lim_q <= 1'b0;
    end
  end

  // remember which port issued the granted read, rdata is ready next cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      order_rvalid <= 1'b0;
      limit_rvalid <= 1'b0;
    end else begin
      order_rvalid <= order_gnt && order_is_rd;
      limit_rvalid <= limit_gnt && limit_is_rd;
    end
  end

  // a limit request that lost to the order engine is served next
  a_rr_to_limit: assert property (
    @(posedge clk) disable iff (!rst_n)
    (order_gnt && limit_req.en) |=> limit_gnt
  ) else $error("account_arbiter: waiting limit request not served next");

  // and the other way round
  a_rr_to_order: assert property (
    @(posedge clk) disable iff (!rst_n)
    (limit_gnt && order_req.en) |=> order_gnt
  ) else $error("account_arbiter: waiting order request not served next");

endmodule

// File: account_store.sv
module account_store (
  input  logic                   clk,
  input  logic                   rst_n,
  input  pretrade_pkg::mem_req_t req,
  output pretrade_pkg::account_t rdata
);
  import pretrade_pkg::*;

  account_t mem_q [num_clients]; // one word per client
  logic     rd_en;

  assign rd_en = req.en && !req.wr_lim && !req.wr_acc;

  // reset gives every client a zero limit and zero exposure
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_clients; i++) begin
        mem_q[i] <= '0;
      end
    end else if (req.en) begin
      if (req.wr_lim) begin
        mem_q[req.addr][account_w-1 -: amount_w] <= req.wdata[account_w-1 -: amount_w];
      end
      if (req.wr_acc) begin
        mem_q[req.addr][amount_w-1:0] <= req.wdata[amount_w-1:0]; // lower half only
      end
    end
  end

  // registered read, data valid the cycle after the grant
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata <= mem_q[req.addr];
    end
  end

  // each engine owns one half, so no request writes both
  a_one_half_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    req.en |-> !(req.wr_lim && req.wr_acc)
  ) else $error("account_store: request writes both halves of client %0d", req.addr);

endmodule

// File: limit_update.sv
module limit_update (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     limit_strobe,
  input  pretrade_pkg::client_id_t client_id,
  input  pretrade_pkg::amount_t    new_limit,
  input  logic                     gnt,
  input  logic                     rvalid,
  input  pretrade_pkg::account_t   rdata,
  output pretrade_pkg::mem_req_t   req,
  output logic                     busy,
  output logic                     limit_done,
  output logic                     applied,
  output pretrade_pkg::amount_t    limit_value
);
  import pretrade_pkg::*;

  limit_state_e state_q;
  logic         rd_sent_q;
  client_id_t   client_q;
  amount_t      new_lim_q;
  account_t     acct_q;
  logic         apply_c;

  assign busy = (state_q != lim_idle);

  // new limit must sit above current exposure
  assign apply_c = new_lim_q > acct_q[amount_w-1:0];

  always_comb begin
    req      = '0;
    req.addr = client_q;
    if (state_q == lim_rd) begin
      req.en = !rd_sent_q;
    end else if (state_q == lim_wr) begin
      req.en     = 1'b1;
      req.wr_lim = 1'b1; // upper half only
      req.wdata  = {new_lim_q, {amount_w{1'b0}}};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= lim_idle;
      rd_sent_q   <= 1'b0;
      limit_done  <= 1'b0;
      applied     <= 1'b0;
      limit_value <= '0;
    end else begin
      limit_done <= 1'b0;
      case (state_q)
        lim_idle: if (limit_strobe) state_q <= lim_rd;
        lim_rd: begin
          if (gnt) rd_sent_q <= 1'b1;
          if (rvalid) begin
            rd_sent_q <= 1'b0;
            state_q   <= lim_calc;
          end
        end
        lim_calc: begin
          if (apply_c) begin
            state_q <= lim_wr;
          end else begin
            limit_done  <= 1'b1;
            applied     <= 1'b0;
            limit_value <= acct_q[account_w-1 -: amount_w]; // old limit stays
            state_q     <= lim_idle;
          end
        end
        lim_wr: begin
          if (gnt) begin
            limit_done  <= 1'b1;
            applied     <= 1'b1;
            limit_value <= new_lim_q;
            state_q     <= lim_idle;
          end
        end
        default: state_q <= lim_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == lim_idle && limit_strobe) begin
      client_q  <= client_id;
      new_lim_q <= new_limit;
    end
    if (state_q == lim_rd && rvalid) acct_q <= rdata;
  end

  // rvalid routed here only after our own read went out
  a_rvalid_own_read: assert property (
    @(posedge clk) disable iff (!rst_n)
    rvalid |-> (state_q == lim_rd && rd_sent_q)
  ) else $error("limit_update: rvalid without an outstanding read");

endmodule

// File: order_risk_check.sv
module order_risk_check (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     order_strobe,
  input  pretrade_pkg::client_id_t client_id,
  input  pretrade_pkg::amount_t    amount,
  input  pretrade_pkg::amount_t    cancelled,
  input  logic                     gnt,
  input  logic                     rvalid,
  input  pretrade_pkg::account_t   rdata,
  output pretrade_pkg::mem_req_t   req,
  output logic                     busy,
  output logic                     order_done,
  output logic                     accepted,
  output pretrade_pkg::amount_t    accumulated
);
  import pretrade_pkg::*;

  order_state_e state_q;
  logic         rd_sent_q; // read granted, waiting for rvalid

  // order latched on the strobe
  client_id_t client_q;
  amount_t    amount_q;
  amount_t    cancel_q;

  account_t   acct_q;   // account word as read
  amount_t    result_q; // new accumulated, held through wr

  amount_t    lim_cur;
  amount_t    acc_cur;
  amount_t    result_c;
  logic       accept_c;

  assign busy = (state_q != ord_idle);

  assign lim_cur = acct_q[account_w-1 -: amount_w];
  assign acc_cur = acct_q[amount_w-1:0];

  // exposure after this order, wraps mod 2^16
  assign result_c = acc_cur - cancel_q + amount_q;

  // limit zero-extended, result taken as signed
  // so a net negative exposure passes any nonzero limit
  assign accept_c = $signed({1'b0, lim_cur}) > $signed({result_c[amount_w-1], result_c});

  always_comb begin
    req      = '0;
    req.addr = client_q;
    case (state_q)
      ord_rd: begin
        req.en = !rd_sent_q; // drop after the grant
      end
      ord_wr: begin
        req.en     = 1'b1;
        req.wr_acc = 1'b1;   // lower half, the limit stays untouched
        req.wdata  = {{amount_w{1'b0}}, result_q};
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= ord_idle;
      rd_sent_q   <= 1'b0;
      order_done  <= 1'b0;
      accepted    <= 1'b0;
      accumulated <= '0;
    end else begin
      order_done <= 1'b0; // one-cycle pulse
      case (state_q)
        ord_idle: begin
          if (order_strobe) begin
            state_q <= ord_rd;
          end
        end
        ord_rd: begin
          if (gnt) begin
            rd_sent_q <= 1'b1;
          end
          if (rvalid) begin
            rd_sent_q <= 1'b0;
            state_q   <= ord_calc;
          end
        end
        ord_calc: begin
          if (accept_c) begin
            state_q <= ord_wr;
          end else begin
            order_done  <= 1'b1; // reject, nothing written
            accepted    <= 1'b0;
            accumulated <= acc_cur;
            state_q     <= ord_idle;
          end
        end
        ord_wr: begin
          if (gnt) begin
            order_done  <= 1'b1; // write lands on this edge
            accepted    <= 1'b1;
            accumulated <= result_q;
            state_q     <= ord_idle;
          end
        end
        default: state_q <= ord_idle;
      endcase
    end
  end

  // payload regs
  always_ff @(posedge clk) begin
    if (state_q == ord_idle && order_strobe) begin
      client_q <= client_id;
      amount_q <= amount;
      cancel_q <= cancelled;
    end
    if (state_q == ord_rd && rvalid) begin
      acct_q <= rdata;
    end
    if (state_q == ord_calc) begin
      result_q <= result_c;
    end
  end

  // read data only comes back for our own granted read
  a_rvalid_own_read: assert property (
    @(posedge clk) disable iff (!rst_n)
    rvalid |-> (state_q == ord_rd && rd_sent_q)
  ) else $error("order_risk_check: rvalid without an outstanding read");

endmodule

// File: pretrade_pkg.sv
package pretrade_pkg;

  // account layout
  localparam int num_clients = 32;          // one account word per client
  localparam int client_w    = 5;           // log2(num_clients)
  localparam int amount_w    = 16;          // every amount and the limit
  localparam int account_w   = 2 * amount_w; // limit half + accumulated half

  // client index into the account store
  typedef logic [client_w-1:0] client_id_t;

  // order, cancelled, accumulated or limit value
  typedef logic [amount_w-1:0] amount_t;

  // [31:16] limit, [15:0] accumulated open amount
  typedef logic [account_w-1:0] account_t;

  // one request into the account store
  // a request with both write bits clear is a read
  typedef struct packed {
    logic       en;     // request this cycle
    logic       wr_lim; // write upper half
    logic       wr_acc; // write lower half
    client_id_t addr;   // which client
    account_t   wdata;  // only the enabled halves matter
  } mem_req_t;

  // order engine FSM
  typedef enum logic [1:0] {
    ord_idle, // waiting for a strobe
    ord_rd,   // read request out, then wait for rvalid
    ord_calc, // risk arithmetic on the captured word
    ord_wr    // write back the new accumulated amount
  } order_state_e;

  // limit engine FSM, same shape as the order engine
  typedef enum logic [1:0] {
    lim_idle,
    lim_rd,
    lim_calc,
    lim_wr
  } limit_state_e;

endpackage

// File: pretrade_risk.f
pretrade_pkg.sv
account_store.sv
account_arbiter.sv
order_risk_check.sv
limit_update.sv
pretrade_risk_top.sv
pretrade_risk_tb.sv

// File: pretrade_risk_tb.sv
module pretrade_risk_tb;
  import pretrade_pkg::*;

  typedef enum logic [1:0] {
    op_order, // order strobe only
    op_limit, // limit strobe only
    op_both   // both strobes on the same edge
  } op_kind_e;

  // one table row, stimulus plus expected results
  typedef struct packed {
    op_kind_e   kind;
    client_id_t oc;      // order client
    client_id_t lc;      // limit client
    amount_t    amt;
    amount_t    canc;
    amount_t    nlim;
    logic       tab;     // row carries its own expected values
    logic       exp_ok;
    amount_t    exp_acc;
    logic       exp_app;
    amount_t    exp_lim;
  } op_t;

  logic       clk;
  logic       rst_n;
  logic       order_strobe;
  logic       limit_strobe;
  client_id_t order_client;
  client_id_t limit_client;
  amount_t    order_amount;
  amount_t    cancelled;
  amount_t    new_limit;
  logic       order_busy;
  logic       order_done;
  logic       accepted;
  logic       limit_busy;
  logic       limit_done;
  logic       applied;
  amount_t    accumulated;
  amount_t    limit_value;

  op_t         ops[$];
  amount_t     lim_m [num_clients]; // reference account model
  amount_t     acc_m [num_clients];
  logic [31:0] lcg_state;

  // results captured on the done pulses
  logic    seen_o;
  logic    seen_l;
  logic    got_ok;
  logic    got_app;
  amount_t got_acc;
  amount_t got_lim;

  pretrade_risk_top dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .order_strobe (order_strobe),
    .limit_strobe (limit_strobe),
    .order_client (order_client),
    .limit_client (limit_client),
    .order_amount (order_amount),
    .cancelled    (cancelled),
    .new_limit    (new_limit),
    .order_busy   (order_busy),
    .order_done   (order_done),
    .accepted     (accepted),
    .limit_busy   (limit_busy),
    .limit_done   (limit_done),
    .applied      (applied),
    .accumulated  (accumulated),
    .limit_value  (limit_value)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // period 40
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic check_amount(input amount_t got, input amount_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic add_op(input op_kind_e kind, input client_id_t oc, input client_id_t lc,
                        input amount_t amt, input amount_t canc, input amount_t nlim,
                        input logic exp_ok, input amount_t exp_acc,
                        input logic exp_app, input amount_t exp_lim);
    ops.push_back('{kind, oc, lc, amt, canc, nlim, 1'b1, exp_ok, exp_acc, exp_app, exp_lim});
  endtask

  task automatic build_directed_ops();
    add_op(op_order, 5'd3, 5'd0, 16'd10, 16'd0, 16'd0, 1'b0, 16'd0, 1'b0, 16'd0); // zero limit
    add_op(op_limit, 5'd0, 5'd3, 16'd0, 16'd0, 16'd100, 1'b0, 16'd0, 1'b1, 16'd100);
    add_op(op_limit, 5'd0, 5'd3, 16'd0, 16'd0, 16'd0, 1'b0, 16'd0, 1'b0, 16'd100);
    add_op(op_order, 5'd3, 5'd0, 16'd40, 16'd0, 16'd0, 1'b1, 16'd40, 1'b0, 16'd0);
    add_op(op_order, 5'd3, 5'd0, 16'd50, 16'd0, 16'd0, 1'b1, 16'd90, 1'b0, 16'd0);
    add_op(op_limit, 5'd0, 5'd3, 16'd0, 16'd0, 16'd90, 1'b0, 16'd0, 1'b0, 16'd100); // equal
    add_op(op_limit, 5'd0, 5'd3, 16'd0, 16'd0, 16'd80, 1'b0, 16'd0, 1'b0, 16'd100); // below
    add_op(op_order, 5'd3, 5'd0, 16'd20, 16'd0, 16'd0, 1'b0, 16'd90, 1'b0, 16'd0); // 110 over
    add_op(op_order, 5'd3, 5'd0, 16'd20, 16'd30, 16'd0, 1'b1, 16'd80, 1'b0, 16'd0);
    add_op(op_order, 5'd5, 5'd0, 16'd5, 16'd0, 16'd0, 1'b0, 16'd0, 1'b0, 16'd0);
    add_op(op_limit, 5'd0, 5'd5, 16'd0, 16'd0, 16'd1, 1'b0, 16'd0, 1'b1, 16'd1);
    // net negative exposure passes a limit of 1
    add_op(op_order, 5'd5, 5'd0, 16'd3, 16'd10, 16'd0, 1'b1, 16'hfff9, 1'b0, 16'd0);
    add_op(op_order, 5'd5, 5'd0, 16'd1, 16'd0, 16'd0, 1'b1, 16'hfffa, 1'b0, 16'd0);
    add_op(op_limit, 5'd0, 5'd5, 16'd0, 16'd0, 16'd200, 1'b0, 16'd0, 1'b0, 16'd1); // unsigned
    add_op(op_order, 5'd5, 5'd0, 16'd6, 16'd0, 16'd0, 1'b1, 16'd0, 1'b0, 16'd0);  // wraps to 0
    add_op(op_limit, 5'd0, 5'd5, 16'd0, 16'd0, 16'd200, 1'b0, 16'd0, 1'b1, 16'd200);
    // same edge, same client: both engines see the old word
    add_op(op_both, 5'd3, 5'd3, 16'd15, 16'd0, 16'd85, 1'b1, 16'd95, 1'b1, 16'd85);
    add_op(op_both, 5'd5, 5'd7, 16'd50, 16'd0, 16'd500, 1'b1, 16'd50, 1'b1, 16'd500);
    add_op(op_both, 5'd7, 5'd7, 16'd400, 16'd0, 16'd300, 1'b1, 16'd400, 1'b1, 16'd300);
    add_op(op_order, 5'd7, 5'd0, 16'd0, 16'd0, 16'd0, 1'b0, 16'd400, 1'b0, 16'd0); // lim 300
    add_op(op_limit, 5'd0, 5'd7, 16'd0, 16'd0, 16'd401, 1'b0, 16'd0, 1'b1, 16'd401);
    add_op(op_order, 5'd3, 5'd0, 16'd0, 16'd20, 16'd0, 1'b1, 16'd75, 1'b0, 16'd0); // lim 85
  endtask

  // random rows on four clients so that accounts collide often
  task automatic build_random_ops();
    logic [31:0] r;
    logic [31:0] k;
    op_t         op;
    for (int i = 0; i < 40; i++) begin
      op = '0;
      r = lcg_next();
      k = (r >> 16) % 32'd3;
      op.kind = (k == 0) ? op_order : (k == 1) ? op_limit : op_both;
      r = lcg_next();
      op.oc = client_id_t'((r >> 16) % 32'd4);
      r = lcg_next();
      op.lc = client_id_t'((r >> 16) % 32'd4);
      r = lcg_next();
      op.amt = amount_t'((r >> 16) % 32'd120);
      r = lcg_next();
      op.canc = ((r >> 16) % 32'd4 == 0) ? amount_t'((r >> 20) % 32'd150) : 16'd0;
      r = lcg_next();
      op.nlim = amount_t'((r >> 16) % 32'd600);
      ops.push_back(op); // tab clear, model only
    end
  endtask

  // wait for the wanted done pulses, sampled on the falling edge
  task automatic wait_done(input logic want_o, input logic want_l, input int idx);
    int cyc;
    cyc    = 0;
    seen_o = !want_o;
    seen_l = !want_l;
    while (!(seen_o && seen_l) && cyc < 50) begin
      @(negedge clk);
      cyc++;
      if (want_o && order_done && !seen_o) begin
        seen_o  = 1'b1;
        got_ok  = accepted;
        got_acc = accumulated;
      end
      if (want_l && limit_done && !seen_l) begin
        seen_l  = 1'b1;
        got_app = applied;
        got_lim = limit_value;
      end
    end
    if (!(seen_o && seen_l)) begin
      $display("timeout: operation %0d got no done pulse within 50 cycles", idx);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic run_op(input op_t op, input int idx);
    logic    do_o;
    logic    do_l;
    logic    m_ok;
    logic    m_app;
    amount_t m_acc;
    amount_t m_lim;
    amount_t sum;
    int      sum_s;
    do_o = (op.kind != op_limit);
    do_l = (op.kind != op_order);
    // both engines judge against the account as it was before this row
    sum   = acc_m[op.oc] - op.canc + op.amt;
    sum_s = sum[amount_w-1] ? int'(sum) - 65536 : int'(sum); // two's complement view
    m_ok  = int'(lim_m[op.oc]) > sum_s;
    m_acc = m_ok ? sum : acc_m[op.oc];
    m_app = op.nlim > acc_m[op.lc];
    m_lim = m_app ? op.nlim : lim_m[op.lc];

    @(posedge clk);
    #2;
    order_client = op.oc;
    limit_client = op.lc;
    order_amount = op.amt;
    cancelled    = op.canc;
    new_limit    = op.nlim;
    order_strobe = do_o;
    limit_strobe = do_l;
    @(posedge clk);
    #2;
    order_strobe = 1'b0; // one-cycle strobes
    limit_strobe = 1'b0;
    // strobed engines left idle on that edge
    check_flag(order_busy, do_o, $sformatf("op %0d order_busy after strobe", idx));
    check_flag(limit_busy, do_l, $sformatf("op %0d limit_busy after strobe", idx));

    wait_done(do_o, do_l, idx);
    check_flag(order_busy, 1'b0, $sformatf("op %0d order_busy after done", idx));
    check_flag(limit_busy, 1'b0, $sformatf("op %0d limit_busy after done", idx));
    if (do_o) begin
      check_flag(got_ok, m_ok, $sformatf("op %0d accepted vs model", idx));
      check_amount(got_acc, m_acc, $sformatf("op %0d accumulated vs model", idx));
      if (op.tab) begin
        check_flag(got_ok, op.exp_ok, $sformatf("op %0d accepted vs table", idx));
        check_amount(got_acc, op.exp_acc, $sformatf("op %0d accumulated vs table", idx));
      end
      acc_m[op.oc] = m_acc;
    end
    if (do_l) begin
      check_flag(got_app, m_app, $sformatf("op %0d applied vs model", idx));
      check_amount(got_lim, m_lim, $sformatf("op %0d limit_value vs model", idx));
      if (op.tab) begin
        check_flag(got_app, op.exp_app, $sformatf("op %0d applied vs table", idx));
        check_amount(got_lim, op.exp_lim, $sformatf("op %0d limit_value vs table", idx));
      end
      lim_m[op.lc] = m_lim;
    end
  endtask

  initial begin
    lcg_state    = 32'd15926;
    rst_n        = 1'b0;
    order_strobe = 1'b0;
    limit_strobe = 1'b0;
    order_client = '0;
    limit_client = '0;
    order_amount = '0;
    cancelled    = '0;
    new_limit    = '0;
    for (int i = 0; i < num_clients; i++) begin
      lim_m[i] = '0; // matches the store after reset
      acc_m[i] = '0;
    end
    build_directed_ops();
    build_random_ops();

    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_flag(order_busy, 1'b0, "order_busy after reset");
    check_flag(limit_busy, 1'b0, "limit_busy after reset");
    check_flag(order_done, 1'b0, "order_done after reset");
    check_flag(limit_done, 1'b0, "limit_done after reset");

    foreach (ops[i]) begin
      run_op(ops[i], i);
    end

    $display("sim passed");
    $finish;
  end

endmodule

// File: pretrade_risk_top.sv
module pretrade_risk_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     order_strobe,
  input  logic                     limit_strobe,
  input  pretrade_pkg::client_id_t order_client,
  input  pretrade_pkg::client_id_t limit_client,
  input  pretrade_pkg::amount_t    order_amount,
  input  pretrade_pkg::amount_t    cancelled,
  input  pretrade_pkg::amount_t    new_limit,
  output logic                     order_busy,
  output logic                     order_done,
  output logic                     accepted,
  output logic                     limit_busy,
  output logic                     limit_done,
  output logic                     applied,
  output pretrade_pkg::amount_t    accumulated,
  output pretrade_pkg::amount_t    limit_value
);
  import pretrade_pkg::*;

  mem_req_t order_req;  // order engine -> arbiter
  mem_req_t limit_req;  // limit engine -> arbiter
  mem_req_t mem_req;    // arbiter -> store
  account_t rdata;      // store -> both engines
  logic     order_gnt;
  logic     limit_gnt;
  logic     order_rvalid;
  logic     limit_rvalid;

  order_risk_check order_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .order_strobe (order_strobe),
    .client_id    (order_client),
    .amount       (order_amount),
    .cancelled    (cancelled),
    .gnt          (order_gnt),
    .rvalid       (order_rvalid),
    .rdata        (rdata),
    .req          (order_req),
    .busy         (order_busy),
    .order_done   (order_done),
    .accepted     (accepted),
    .accumulated  (accumulated)
  );

  limit_update limit_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .limit_strobe (limit_strobe),
    .client_id    (limit_client),
    .new_limit    (new_limit),
    .gnt          (limit_gnt),
    .rvalid       (limit_rvalid),
    .rdata        (rdata),
    .req          (limit_req),
    .busy         (limit_busy),
    .limit_done   (limit_done),
    .applied      (applied),
    .limit_value  (limit_value)
  );

  account_arbiter arb_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .order_req    (order_req),
    .limit_req    (limit_req),
    .order_gnt    (order_gnt),
    .limit_gnt    (limit_gnt),
    .order_rvalid (order_rvalid),
    .limit_rvalid (limit_rvalid),
    .mem_req      (mem_req)
  );

  account_store store_i (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (mem_req),
    .rdata (rdata)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# build the pre-trade risk gate testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
  -f pretrade_risk.f \
  --top-module pretrade_risk_tb \
  -o pretrade_risk_sim
./obj_dir/pretrade_risk_sim
